// File: sources.f
verilog/hub75_pixel_pkg.sv
verilog/hub75_scan_pkg.sv
verilog/column_xfer_if.sv
verilog/column_loader.sv
verilog/half_plane_shifter.sv
verilog/hub75_output.sv
verilog/pov_hub75_top.sv
tb/tb_pov_hub75.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
   echo "cannot enter the project directory"
   exit 1
fi

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary -Wno-fatal -f sources.f --top-module tb_pov_hub75 \
   --Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"

if grep -qF '*** PASSED ***' "$LOG_FILE"; then
   if [ $run_status -ne 0 ]; then
      echo "simulator returned status $run_status"
      exit 1
   fi
   exit 0
fi
echo "pass message not found in $LOG_FILE"
exit 1

// File: tb/tb_pov_hub75.sv
`timescale 1ns/100ps

module tb_pov_hub75;

   localparam int NUM_COLS    = 8;
   localparam int SCAN_RATE   = 32;
   localparam int PERIOD      = 4;
   localparam int NUM_PLANES  = 3;
   localparam int COL_W       = $clog2(NUM_COLS);
   localparam int ADDR_W      = $clog2(SCAN_RATE);
   localparam int SCAN_CYCLES = 3 * NUM_COLS + 6 * PERIOD + 1;   // take to idle

   logic                    clk_in;
   logic                    rst_in;
   logic                    wr_en;
   logic                    wr_half;
   logic [COL_W-1:0]        wr_col;
   hub75_pixel_pkg::pixel_t wr_pixel;
   logic                    commit;
   logic [ADDR_W-1:0]       commit_address;
   logic [2:0]              rgb0;
   logic [2:0]              rgb1;
   logic                    led_clk;
   logic                    led_latch;
   logic                    led_output_enable;
   logic [ADDR_W-1:0]       hub75_address;
   logic                    scan_ready;
   logic                    scan_last;

   hub75_pixel_pkg::pixel_t model [2][NUM_COLS];   // what the buffer holds now
   hub75_pixel_pkg::pixel_t shown [2][NUM_COLS];   // what the running scan must show

   logic [15:0] lfsr_state = 16'd68;

   // monitor records
   logic [2:0] rgb0_q [$];
   logic [2:0] rgb1_q [$];
   int         pulse_q [$];   // led_clk pulses before each latch
   int         oe_q [$];      // oe low run after each latch
   int         clk_cnt = 0;
   int         oe_cnt = 0;
   int         last_cnt = 0;
   logic       prev_ready = 1'b1;
   logic       prev_last = 1'b0;

   pov_hub75_top #(
      .NUM_COLS  (NUM_COLS),
      .SCAN_RATE (SCAN_RATE),
      .PERIOD    (PERIOD)
   ) i_dut (
      .clk_in            (clk_in),
      .rst_in            (rst_in),
      .wr_en             (wr_en),
      .wr_half           (wr_half),
      .wr_col            (wr_col),
      .wr_pixel          (wr_pixel),
      .commit            (commit),
      .commit_address    (commit_address),
      .rgb0              (rgb0),
      .rgb1              (rgb1),
      .led_clk           (led_clk),
      .led_latch         (led_latch),
      .led_output_enable (led_output_enable),
      .hub75_address     (hub75_address),
      .scan_ready        (scan_ready),
      .scan_last         (scan_last)
   );

   initial begin
      clk_in = 1'b0;
      forever #50 clk_in = ~clk_in;
   end

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("*** FAILED ***");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic expect_equal(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
      assert (got === expected) else begin
         stop_on_error($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, expected));
      end
   endtask

   // galois form, taps 16,14,13,11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic random_pixel(output hub75_pixel_pkg::pixel_t px);
      for (int i = 0; i < 9; i++) begin
         px[i]      = lfsr_state[0];
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   // bit p of each channel, red on top
   function automatic logic [2:0] plane_bits(input hub75_pixel_pkg::pixel_t px, input int p);
      return {px.red[p], px.green[p], px.blue[p]};
   endfunction

   // called once per cycle, mid high phase where led_clk and rgb are steady
   task automatic record_outputs();
      if (rst_in) begin
         prev_ready = 1'b1;
         prev_last  = 1'b0;
      end else begin
         if (led_clk) begin
            rgb0_q.push_back(rgb0);
            rgb1_q.push_back(rgb1);
            clk_cnt++;
         end
         if (led_latch) begin
            pulse_q.push_back(clk_cnt);
            clk_cnt = 0;
         end
         if (!led_output_enable) begin
            oe_cnt++;
         end else if (oe_cnt != 0) begin
            oe_q.push_back(oe_cnt);
            oe_cnt = 0;
         end
         if (scan_last) begin
            last_cnt++;
            expect_equal("scan_ready", scan_ready, 0);
         end
         if (scan_ready && !prev_ready) begin
            expect_equal("scan_last", prev_last, 1);   // must flag the cycle before
         end
         prev_ready = scan_ready;
         prev_last  = scan_last;
      end
   endtask

   initial begin
      forever begin
         @(posedge clk_in);
         #25;
         record_outputs();
      end
   end

   task automatic clear_monitor();
      rgb0_q.delete();
      rgb1_q.delete();
      pulse_q.delete();
      oe_q.delete();
      clk_cnt  = 0;
      oe_cnt   = 0;
      last_cnt = 0;
   endtask

   task automatic wait_ready(input logic level, input int limit);
      int n;
      n = 0;
      do begin
         @(posedge clk_in);
         #25;
         n++;
      end while (scan_ready !== level && n < limit);
      if (scan_ready !== level) begin
         stop_on_error($sformatf("timeout while waiting for scan_ready to go %0d", level));
      end
   endtask

   task automatic write_pixel(input int half, input int col, input hub75_pixel_pkg::pixel_t px);
      @(posedge clk_in);
      wr_en    <= 1'b1;
      wr_half  <= half[0];
      wr_col   <= col[COL_W-1:0];
      wr_pixel <= px;
      model[half][col] = px;
   endtask

   task automatic stop_writes();
      @(posedge clk_in);
      wr_en <= 1'b0;
   endtask

   task automatic fill_column();
      hub75_pixel_pkg::pixel_t px;
      for (int h = 0; h < 2; h++) begin
         for (int c = 0; c < NUM_COLS; c++) begin
            random_pixel(px);
            write_pixel(h, c, px);
         end
      end
      stop_writes();
   endtask

   task automatic commit_column(input logic [ADDR_W-1:0] addr);
      @(posedge clk_in);
      wr_en          <= 1'b0;
      commit         <= 1'b1;
      commit_address <= addr;
      @(posedge clk_in);
      commit <= 1'b0;
   endtask

   // follows one scan to its end and compares it with shown
   task automatic check_scan(input logic [ADDR_W-1:0] addr);
      wait_ready(1'b0, 20);
      expect_equal("hub75_address", hub75_address, addr);
      wait_ready(1'b1, SCAN_CYCLES + 20);
      @(posedge clk_in);
      expect_equal("led_latch pulses", pulse_q.size(), NUM_PLANES);
      expect_equal("led_output_enable low runs", oe_q.size(), NUM_PLANES);
      expect_equal("rgb0 samples", rgb0_q.size(), NUM_PLANES * NUM_COLS);
      expect_equal("rgb1 samples", rgb1_q.size(), NUM_PLANES * NUM_COLS);
      for (int p = 0; p < NUM_PLANES; p++) begin
         expect_equal("led_clk pulses", pulse_q[p], NUM_COLS);
         expect_equal("led_output_enable low cycles", oe_q[p], PERIOD * (p + 1));
         for (int c = 0; c < NUM_COLS; c++) begin
            expect_equal("rgb0", rgb0_q[p * NUM_COLS + c], plane_bits(shown[0][c], p));
            expect_equal("rgb1", rgb1_q[p * NUM_COLS + c], plane_bits(shown[1][c], p));
         end
      end
      expect_equal("scan_last cycles", last_cnt, 1);
      clear_monitor();
   endtask

   task automatic test_reset_state();
      repeat (4) begin
         @(posedge clk_in);
         #25;
         expect_equal("scan_ready", scan_ready, 1);
         expect_equal("led_latch", led_latch, 0);
         expect_equal("led_output_enable", led_output_enable, 1);
         expect_equal("led_clk", led_clk, 0);
         expect_equal("scan_last", scan_last, 0);
      end
   endtask

   task automatic test_single_column();
      @(posedge clk_in);
      clear_monitor();
      fill_column();
      shown = model;
      commit_column(5'd5);
      check_scan(5'd5);
   endtask

   task automatic test_back_pressure();
      hub75_pixel_pkg::pixel_t px;
      fill_column();
      shown = model;
      commit_column(5'd9);
      wait_ready(1'b0, 20);
      fill_column();                // next column while the first is shown
      commit_column(5'd12);
      for (int c = 0; c < NUM_COLS / 2; c++) begin
         random_pixel(px);
         write_pixel(0, c, px);
      end
      commit_column(5'd20);         // only the row changes
      #25;
      expect_equal("scan_ready", scan_ready, 0);
      check_scan(5'd9);
      shown = model;                // buffer as it stood at the second take
      check_scan(5'd20);
   endtask

   task automatic test_capture_isolation();
      fill_column();
      shown = model;
      commit_column(5'd3);
      wait_ready(1'b0, 20);
      for (int h = 0; h < 2; h++) begin
         for (int c = 0; c < NUM_COLS; c++) begin
            write_pixel(h, c, ~shown[h][c]);
         end
      end
      stop_writes();
      check_scan(5'd3);
   endtask

   initial begin
      rst_in         = 1'b1;
      wr_en          = 1'b0;
      wr_half        = 1'b0;
      wr_col         = '0;
      wr_pixel       = '0;
      commit         = 1'b0;
      commit_address = '0;
      repeat (5) @(posedge clk_in);
      rst_in <= 1'b0;

      test_reset_state();
      test_single_column();
      test_back_pressure();
      test_capture_isolation();

      $display("*** PASSED ***");
      $finish;
   end

endmodule

// File: verilog/pov_hub75_top.sv
`timescale 1ns/100ps

module pov_hub75_top #(
   parameter int NUM_COLS  = 64,
   parameter int SCAN_RATE = 32,
   parameter int PERIOD    = 100    // base lit time in cycles
) (
   input  logic                         clk_in,
   input  logic                         rst_in,
   input  logic                         wr_en,
   input  logic                         wr_half,
   input  logic [$clog2(NUM_COLS)-1:0]  wr_col,
   input  hub75_pixel_pkg::pixel_t      wr_pixel,
   input  logic                         commit,
   input  logic [$clog2(SCAN_RATE)-1:0] commit_address,
   output logic [2:0]                   rgb0,
   output logic [2:0]                   rgb1,
   output logic                         led_clk,
   output logic                         led_latch,
   output logic                         led_output_enable,
   output logic [$clog2(SCAN_RATE)-1:0] hub75_address,
   output logic                         scan_ready,    // ready level for commits
   output logic                         scan_last
);

   column_xfer_if #(.NUM_COLS(NUM_COLS), .SCAN_RATE(SCAN_RATE)) xfer ();

   logic [$clog2(NUM_COLS)-1:0] pixel_idx;
   hub75_scan_pkg::plane_t      plane;
   hub75_pixel_pkg::rgb_bits_t  half_rgb [hub75_pixel_pkg::NUM_HALVES];

   column_loader #(
      .NUM_COLS  (NUM_COLS),
      .SCAN_RATE (SCAN_RATE)
   ) i_loader (
      .clk_in         (clk_in),
      .rst_in         (rst_in),
      .wr_en          (wr_en),
      .wr_half        (wr_half),
      .wr_col         (wr_col),
      .wr_pixel       (wr_pixel),
      .commit         (commit),
      .commit_address (commit_address),
      .xfer           (xfer)
   );

   // one shifter per panel half, 0 upper, 1 lower
   for (genvar h = 0; h < hub75_pixel_pkg::NUM_HALVES; h++) begin : g_half
      half_plane_shifter #(
         .NUM_COLS   (NUM_COLS),
         .HALF_INDEX (h)
      ) i_shifter (
         .clk_in    (clk_in),
         .xfer      (xfer),
         .pixel_idx (pixel_idx),
         .plane     (plane),
         .rgb       (half_rgb[h])
      );
   end

   hub75_output #(
      .NUM_COLS  (NUM_COLS),
      .SCAN_RATE (SCAN_RATE),
      .PERIOD    (PERIOD)
   ) i_output (
      .clk_in            (clk_in),
      .rst_in            (rst_in),
      .xfer              (xfer),
      .rgb_upper         (half_rgb[0]),
      .rgb_lower         (half_rgb[1]),
      .pixel_idx         (pixel_idx),
      .plane             (plane),
      .rgb0              (rgb0),
      .rgb1              (rgb1),
      .led_clk           (led_clk),
      .led_latch         (led_latch),
      .led_output_enable (led_output_enable),
      .hub75_address     (hub75_address),
      .scan_ready        (scan_ready),
      .scan_last         (scan_last)
   );

endmodule

// File: verilog/hub75_output.sv
`timescale 1ns/100ps

module hub75_output #(
   parameter int NUM_COLS  = 64,
   parameter int SCAN_RATE = 32,
   parameter int PERIOD    = 100
) (
   input  logic                         clk_in,
   input  logic                         rst_in,
   column_xfer_if.sequencer             xfer,
   input  hub75_pixel_pkg::rgb_bits_t   rgb_upper,
   input  hub75_pixel_pkg::rgb_bits_t   rgb_lower,
   output logic [$clog2(NUM_COLS)-1:0]  pixel_idx,
   output hub75_scan_pkg::plane_t       plane,
   output logic [2:0]                   rgb0,
   output logic [2:0]                   rgb1,
   output logic                         led_clk,
   output logic                         led_latch,
   output logic                         led_output_enable,
   output logic [$clog2(SCAN_RATE)-1:0] hub75_address,
   output logic                         scan_ready,
   output logic                         scan_last
);

   // longest hold is PERIOD*NUM_PLANES cycles, counted down to 0
   localparam int HOLD_W = $clog2(PERIOD * hub75_scan_pkg::NUM_PLANES);
   localparam hub75_scan_pkg::plane_t LAST_PLANE = 2'(hub75_scan_pkg::NUM_PLANES - 1);

   hub75_scan_pkg::scan_state_t state;

   logic                        clk_msk;       // led_clk gate, high across SHIFT
   logic [HOLD_W-1:0]           hold_cnt;
   logic [HOLD_W-1:0]           hold_len;
   logic                        final_plane;   // current HOLD ends the scan
   logic                        take;
   logic                        shift_done;
   logic [$clog2(NUM_COLS)-1:0] next_idx;

   // accept decision lives only here
   assign take       = (state == hub75_scan_pkg::IDLE) && xfer.tvalid;
   assign xfer.take  = take;
   assign scan_ready = (state == hub75_scan_pkg::IDLE);
   assign scan_last  = (state == hub75_scan_pkg::HOLD) && final_plane && (hold_cnt == '0);

   assign led_clk = clk_in & clk_msk;

   // pixel_idx runs one pixel ahead of the pins, since the pins load on the
   // falling edge before each led_clk pulse. in SHIFT it reads 1..N-1 and then
   // wraps to 0 on the last shift cycle
   assign next_idx   = (pixel_idx == NUM_COLS - 1) ? '0 : pixel_idx + 1'b1;
   assign shift_done = (state == hub75_scan_pkg::SHIFT) && (pixel_idx == '0);

   // lit time of the plane just shifted, weight p+1
   assign hold_len = HOLD_W'(PERIOD * (int'(plane) + 1) - 1);

   always_ff @(posedge clk_in) begin
      if (rst_in) begin
         state             <= hub75_scan_pkg::IDLE;
         pixel_idx         <= '0;
         plane             <= '0;
         hold_cnt          <= '0;
         final_plane       <= 1'b0;
         clk_msk           <= 1'b0;
         led_latch         <= 1'b0;
         led_output_enable <= 1'b1;   // blanked
         hub75_address     <= '0;
      end else begin
         led_latch <= 1'b0;
         case (state)
            hub75_scan_pkg::IDLE: begin
               if (take) begin
                  state         <= hub75_scan_pkg::SHIFT;
                  hub75_address <= xfer.address;
                  pixel_idx     <= next_idx;
                  clk_msk       <= 1'b1;
               end
            end
            hub75_scan_pkg::SHIFT: begin
               if (shift_done) begin
                  state             <= hub75_scan_pkg::HOLD;
                  clk_msk           <= 1'b0;
                  led_latch         <= 1'b1;
                  led_output_enable <= 1'b0;
                  hold_cnt          <= hold_len;
                  final_plane       <= (plane == LAST_PLANE);
                  // plane moves on now so the next pixel 0 is ready in time
                  plane             <= (plane == LAST_PLANE) ? '0 : plane + 1'b1;
               end else begin
                  pixel_idx <= next_idx;
               end
            end
            hub75_scan_pkg::HOLD: begin
               if (hold_cnt != '0) begin
                  hold_cnt <= hold_cnt - 1'b1;
               end else if (final_plane) begin
                  state             <= hub75_scan_pkg::IDLE;
                  led_output_enable <= 1'b1;
               end else begin
                  state             <= hub75_scan_pkg::SHIFT;
                  led_output_enable <= 1'b1;
                  clk_msk           <= 1'b1;
                  pixel_idx         <= next_idx;
               end
            end
            default: begin
               state <= hub75_scan_pkg::IDLE;
            end
         endcase
      end
   end

   // panel samples on the rising led_clk edge, so change data half a cycle early
   always_ff @(negedge clk_in) begin
      rgb0 <= rgb_upper;
      rgb1 <= rgb_lower;
   end

endmodule

// File: verilog/half_plane_shifter.sv
`timescale 1ns/100ps

module half_plane_shifter #(
   parameter int NUM_COLS   = 64,
   parameter int HALF_INDEX = 0
) (
   input  logic                        clk_in,
   column_xfer_if.shifter              xfer,
   input  logic [$clog2(NUM_COLS)-1:0] pixel_idx,
   input  hub75_scan_pkg::plane_t      plane,
   output hub75_pixel_pkg::rgb_bits_t  rgb
);

   // private copy of this half, taken at accept
   hub75_pixel_pkg::pixel_t [NUM_COLS-1:0] half_q;
   hub75_pixel_pkg::pixel_t                cur_pixel;

   // loader is free to refill its buffer once this lands
   always_ff @(posedge clk_in) begin
      if (xfer.take) begin
         half_q <= xfer.column[HALF_INDEX];
      end
   end

   // pixel 0 leaves on the take cycle itself, before the copy is in place,
   // so read it from the loader buffer then
   always_comb begin
      if (xfer.take) begin
         cur_pixel = xfer.column[HALF_INDEX][pixel_idx];
      end else begin
         cur_pixel = half_q[pixel_idx];
      end
   end

   // bit p of every channel belongs to plane p
   always_comb begin
      rgb.red   = cur_pixel.red[plane];
      rgb.green = cur_pixel.green[plane];
      rgb.blue  = cur_pixel.blue[plane];
   end

endmodule

// File: verilog/column_loader.sv
`timescale 1ns/100ps

module column_loader #(
   parameter int NUM_COLS  = 64,
   parameter int SCAN_RATE = 32
) (
   input  logic                         clk_in,
   input  logic                         rst_in,
   input  logic                         wr_en,
   input  logic                         wr_half,
   input  logic [$clog2(NUM_COLS)-1:0]  wr_col,
   input  hub75_pixel_pkg::pixel_t      wr_pixel,
   input  logic                         commit,
   input  logic [$clog2(SCAN_RATE)-1:0] commit_address,
   column_xfer_if.loader                xfer
);

   // single column buffer, both halves
   // no second copy, so writes after a commit still land in that column
   hub75_pixel_pkg::pixel_t [hub75_pixel_pkg::NUM_HALVES-1:0][NUM_COLS-1:0] buffer;

   logic                         pending;       // commit seen, not yet taken
   logic [$clog2(SCAN_RATE)-1:0] pending_addr;

   // pixel writes
   always_ff @(posedge clk_in) begin
      if (wr_en) begin
         buffer[wr_half][wr_col] <= wr_pixel;
      end
   end

   // pending flag
   // stays up while the sequencer is busy, drops on take
   always_ff @(posedge clk_in) begin
      if (rst_in) begin
         pending <= 1'b0;
      end else if (commit) begin
         pending <= 1'b1;    // new commit survives a same-cycle take
      end else if (xfer.take) begin
         pending <= 1'b0;
      end
   end

   // row address of the waiting column
   always_ff @(posedge clk_in) begin
      if (commit) begin
         pending_addr <= commit_address;   // repeat commit only retargets the row
      end
   end

   assign xfer.tvalid  = pending;
   assign xfer.address = pending_addr;
   assign xfer.column  = buffer;           // shifters copy straight from here

endmodule

// File: verilog/column_xfer_if.sv
`timescale 1ns/100ps

interface column_xfer_if #(
   parameter int NUM_COLS  = 64,
   parameter int SCAN_RATE = 32
);

   logic                         tvalid;   // committed column waiting
   logic [$clog2(SCAN_RATE)-1:0] address;  // scan row of that column
   hub75_pixel_pkg::pixel_t [hub75_pixel_pkg::NUM_HALVES-1:0][NUM_COLS-1:0] column;
   logic                         take;     // one-cycle accept from the sequencer

   modport loader (
      output tvalid,
      output address,
      output column,
      input  take
   );

   modport sequencer (
      input  tvalid,
      input  address,
      output take
   );

   // shifters copy their half on take
   modport shifter (
      input take,
      input column
   );

endinterface

// File: verilog/hub75_scan_pkg.sv
package hub75_scan_pkg;

   // weighted 1:2:3 planes per column
   localparam int NUM_PLANES = 3;

   // plane index, 0 to NUM_PLANES-1
   typedef logic [1:0] plane_t;

   typedef enum logic [1:0] {
      IDLE  = 2'd0,   // waiting for a committed column
      SHIFT = 2'd1,   // pixels clocked out, panel blanked
      HOLD  = 2'd2    // latched plane lit
   } scan_state_t;

endpackage

// File: verilog/hub75_pixel_pkg.sv
package hub75_pixel_pkg;

   // upper and lower panel halves
   localparam int NUM_HALVES = 2;

   // one colour intensity, bit p is shown in plane p
   typedef logic [2:0] chan_t;

   typedef struct packed {
      chan_t red;     // bits 8:6
      chan_t green;
      chan_t blue;    // bits 2:0
   } pixel_t;

   // what one pixel puts on the pins for a single plane
   typedef struct packed {
      logic red;
      logic green;
      logic blue;
   } rgb_bits_t;

endpackage
